//--- hw/cnn_data_pkg.sv
`default_nettype none

package cnn_data_pkg;

  // lane geometry, four signed Q8.8 lanes per word
  localparam int lanes = 4;
  localparam int data_w = 16;
  localparam int word_w = lanes * data_w;
  localparam int frac_bits = 8;

  // one weight tile is a full lanes x lanes matrix
  localparam int tile_w = lanes * word_w;

  // accumulator lanes, plus headroom for bias and skip
  localparam int acc_w = 24;
  localparam int sum_w = acc_w + 2;

  // feature buffers
  localparam int addr_w = 6;
  localparam int depth = 1 << addr_w;

  // weight tiles per pass
  localparam int coef_addr_w = 3;
  localparam int coef_tiles = 1 << coef_addr_w;

  // a quarter for weights, an eighth for bias
  localparam int weight_step = 1 << (frac_bits - 2);
  localparam int bias_step = 1 << (frac_bits - 3);

  // clamp limits of a lane
  localparam logic signed [data_w-1:0] data_max = {1'b0, {(data_w - 1){1'b1}}};
  localparam logic signed [data_w-1:0] data_min = {1'b1, {(data_w - 1){1'b0}}};

endpackage

`default_nettype wire

//--- hw/cnn_pass_pkg.sv
`default_nettype none

package cnn_pass_pkg;

  localparam int pass_w = 3;
  localparam int num_passes = 5;

  // layer pass currently running
  typedef enum logic [pass_w-1:0] {
    pass_0 = 3'd0,
    pass_1 = 3'd1,
    pass_2 = 3'd2,
    pass_3 = 3'd3,
    pass_4 = 3'd4
  } pass_e;

  // even passes read buffer a, odd passes read buffer b
  function automatic logic src_is_b(pass_e p);
    return p inside {pass_1, pass_3};
  endfunction

  // results always go to the buffer not being read
  function automatic logic dst_is_b(pass_e p);
    return !src_is_b(p);
  endfunction

  // skip word is added in the last pass only
  function automatic logic is_residual(pass_e p);
    return p == pass_4;
  endfunction

endpackage

`default_nettype wire

//--- hw/feature_bram.sv
`default_nettype none

module feature_bram (
  input  wire                               clk,
  input  wire                               we,
  input  wire [cnn_data_pkg::addr_w-1:0]    waddr,
  input  wire [cnn_data_pkg::word_w-1:0]    wdata,
  input  wire [cnn_data_pkg::addr_w-1:0]    raddr,
  output logic [cnn_data_pkg::word_w-1:0]   rdata
);

  import cnn_data_pkg::*;

  // one word holds all four lanes
  logic [word_w-1:0] mem [depth];

  // write port
  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // registered read, returns old data on a same-address write
  always_ff @(posedge clk) begin
    rdata <= mem[raddr];
  end

endmodule

`default_nettype wire

//--- hw/coef_rom.sv
`default_nettype none

module coef_rom (
  input  wire                                    clk,
  input  wire cnn_pass_pkg::pass_e               pass,
  input  wire [cnn_data_pkg::coef_addr_w-1:0]    coef_addr,
  output logic [cnn_data_pkg::tile_w-1:0]        weights,
  output logic [cnn_data_pkg::word_w-1:0]        bias
);

  import cnn_data_pkg::*;
  import cnn_pass_pkg::*;

  // one bank per pass
  localparam int bank_w = coef_tiles * tile_w;

  logic [num_passes*bank_w-1:0] weight_tab;
  logic [num_passes*word_w-1:0] bias_tab;
  logic [pass_w-1:0]            bank;

  // weight in quarter steps from -1.0 to +1.0
  function automatic int weight_val(int p, int c, int o, int i);
    return ((p * 7 + c * 3 + o * 5 + i) % 9 - 4) * weight_step;
  endfunction

  function automatic int bias_val(int p, int o);
    return (p - 2 + o) * bias_step;
  endfunction

  // row o of a tile feeds output lane o, column i is input lane i
  for (genvar p = 0; p < num_passes; p++) begin : g_pass
    for (genvar o = 0; o < lanes; o++) begin : g_out
      assign bias_tab[p*word_w + o*data_w +: data_w] = data_w'(bias_val(p, o));
      for (genvar c = 0; c < coef_tiles; c++) begin : g_tile
        for (genvar i = 0; i < lanes; i++) begin : g_in
          assign weight_tab[p*bank_w + c*tile_w + o*word_w + i*data_w +: data_w] =
            data_w'(weight_val(p, c, o, i));
        end
      end
    end
  end

  // unused pass codes fall back to bank 0
  always_comb begin
    bank = pass;
    if (int'(pass) >= num_passes) begin
      bank = '0;
    end
  end

  always_ff @(posedge clk) begin
    weights <= weight_tab[bank*bank_w + coef_addr*tile_w +: tile_w];
    bias    <= bias_tab[bank*word_w +: word_w];
  end

endmodule

`default_nettype wire

//--- hw/operand_select.sv
`default_nettype none

module operand_select (
  input  wire                               clk,
  input  wire                               arst_n,
  input  wire cnn_pass_pkg::pass_e          pass,
  input  wire                               pad,
  input  wire [cnn_data_pkg::word_w-1:0]    buf_a_data,
  input  wire [cnn_data_pkg::word_w-1:0]    buf_b_data,
  input  wire [cnn_data_pkg::word_w-1:0]    skip_data,
  input  wire [cnn_data_pkg::tile_w-1:0]    weights_in,
  input  wire [cnn_data_pkg::word_w-1:0]    bias_in,
  output logic [cnn_data_pkg::word_w-1:0]   operand,
  output logic [cnn_data_pkg::tile_w-1:0]   weights,
  output logic [cnn_data_pkg::word_w-1:0]   bias,
  output logic [cnn_data_pkg::word_w-1:0]   skip
);

  import cnn_data_pkg::*;
  import cnn_pass_pkg::*;

  logic [word_w-1:0] source;

  // source buffer by pass parity, then padding
  always_comb begin
    source = src_is_b(pass) ? buf_b_data : buf_a_data;
    if (pad) begin
      source = '0;
    end
  end

  // all operands leave this stage on the same edge
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      operand <= '0;
      weights <= '0;
      bias    <= '0;
      skip    <= '0;
    end else begin
      operand <= source;
      weights <= weights_in;
      bias    <= bias_in;
      skip    <= skip_data;
    end
  end

endmodule

`default_nettype wire

//--- hw/mac_array.sv
`default_nettype none

module mac_array (
  input  wire                               clk,
  input  wire                               arst_n,
  input  wire                               valid,
  input  wire                               first,
  input  wire                               last,
  input  wire                               residual,
  input  wire [cnn_data_pkg::word_w-1:0]    operand,
  input  wire [cnn_data_pkg::tile_w-1:0]    weights,
  input  wire [cnn_data_pkg::word_w-1:0]    bias,
  input  wire [cnn_data_pkg::word_w-1:0]    skip,
  output logic [cnn_data_pkg::word_w-1:0]   result,
  output logic                              result_valid
);

  import cnn_data_pkg::*;

  logic signed [acc_w-1:0] acc [lanes];
  logic signed [acc_w-1:0] lane_sum [lanes];

  // finishing step side data, held for the result stage
  logic [word_w-1:0] bias_q;
  logic [word_w-1:0] skip_q;
  logic              residual_q;
  logic              last_q;

  logic [word_w-1:0] result_next;

  // row o of the tile against the operand word
  // each Q16.16 product is brought back to Q8.8 before summing
  always_comb begin
    logic signed [2*data_w-1:0] prod;
    logic signed [acc_w-1:0]    sum;
    for (int o = 0; o < lanes; o++) begin
      sum = '0;
      for (int i = 0; i < lanes; i++) begin
        prod = $signed(operand[i*data_w +: data_w]) *
               $signed(weights[o*word_w + i*data_w +: data_w]);
        sum = sum + acc_w'(prod >>> frac_bits);
      end
      lane_sum[o] = sum;
    end
  end

  // accumulators, first step of a word reloads
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int o = 0; o < lanes; o++) begin
        acc[o] <= '0;
      end
      last_q <= 1'b0;
    end else begin
      last_q <= valid & last;
      if (valid) begin
        for (int o = 0; o < lanes; o++) begin
          acc[o] <= first ? lane_sum[o] : acc[o] + lane_sum[o];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (valid) begin
      bias_q     <= bias;
      skip_q     <= skip;
      residual_q <= residual;
    end
  end

  // bias, optional skip, then clamp to the lane range
  always_comb begin
    logic signed [sum_w-1:0] total;
    for (int o = 0; o < lanes; o++) begin
      total = sum_w'(acc[o]) + sum_w'($signed(bias_q[o*data_w +: data_w]));
      if (residual_q) begin
        total = total + sum_w'($signed(skip_q[o*data_w +: data_w]));
      end
      if (total > sum_w'(data_max)) begin
        result_next[o*data_w +: data_w] = data_max;
      end else if (total < sum_w'(data_min)) begin
        result_next[o*data_w +: data_w] = data_min;
      end else begin
        result_next[o*data_w +: data_w] = total[data_w-1:0];
      end
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= last_q;
    end
  end

  // result stays until the next word finishes
  always_ff @(posedge clk) begin
    if (last_q) begin
      result <= result_next;
    end
  end

endmodule

`default_nettype wire

//--- hw/conv_layer.sv
`default_nettype none

module conv_layer (
  input  wire                                   clk,
  input  wire                                   arst_n,
  input  wire                                   host_wr,
  input  wire [cnn_data_pkg::addr_w-1:0]        host_addr,
  input  wire [cnn_data_pkg::word_w-1:0]        host_data,
  input  wire                                   step,
  input  wire cnn_pass_pkg::pass_e              pass,
  input  wire [cnn_data_pkg::addr_w-1:0]        rd_addr,
  input  wire [cnn_data_pkg::addr_w-1:0]        skip_addr,
  input  wire [cnn_data_pkg::coef_addr_w-1:0]   coef_addr,
  input  wire                                   pad,
  input  wire                                   first,
  input  wire                                   last,
  input  wire [cnn_data_pkg::addr_w-1:0]        wr_addr,
  input  wire [cnn_data_pkg::addr_w-1:0]        out_addr,
  output logic [cnn_data_pkg::word_w-1:0]       out_data,
  output logic [cnn_data_pkg::word_w-1:0]       result,
  output logic                                  result_valid
);

  import cnn_data_pkg::*;
  import cnn_pass_pkg::*;

  logic              step_go;
  logic              step_d1, step_d2;
  logic              first_d1, first_d2;
  logic              last_d1, last_d2;
  logic              pad_d1;
  pass_e             pass_d [1:4];
  logic [addr_w-1:0] wr_addr_d [1:4];

  logic              buf_a_we, buf_b_we;
  logic [addr_w-1:0] buf_a_waddr, buf_b_raddr;
  logic [word_w-1:0] buf_a_wdata;
  logic [word_w-1:0] buf_a_rdata, buf_b_rdata, skip_rdata;
  logic [tile_w-1:0] rom_weights, op_weights;
  logic [word_w-1:0] rom_bias, op_bias, op_operand, op_skip;
  logic              residual;

  // host load wins over a step in the same cycle
  assign step_go = step & ~host_wr;

  // strobes of steps in flight
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      {step_d1, step_d2}   <= '0;
      {first_d1, first_d2} <= '0;
      {last_d1, last_d2}   <= '0;
      pad_d1               <= 1'b0;
    end else begin
      {step_d1, step_d2}   <= {step_go, step_d1};
      {first_d1, first_d2} <= {first, first_d1};
      {last_d1, last_d2}   <= {last, last_d1};
      pad_d1               <= pad;
    end
  end

  // pass and destination ride along to the write-back
  always_ff @(posedge clk) begin
    pass_d[1]    <= pass;
    wr_addr_d[1] <= wr_addr;
    for (int i = 2; i <= 4; i++) begin
      pass_d[i]    <= pass_d[i-1];
      wr_addr_d[i] <= wr_addr_d[i-1];
    end
  end

  assign residual = is_residual(pass_d[2]);

  // buffer a takes host data or odd-pass results
  assign buf_a_we    = host_wr | (result_valid & ~dst_is_b(pass_d[4]));
  assign buf_a_waddr = host_wr ? host_addr : wr_addr_d[4];
  assign buf_a_wdata = host_wr ? host_data : result;
  assign buf_b_we    = result_valid & dst_is_b(pass_d[4]);

  // buffer b read port doubles as host readout
  assign buf_b_raddr = step_go ? rd_addr : out_addr;
  assign out_data    = buf_b_rdata;

  feature_bram buf_a_inst (
    .clk   (clk),
    .we    (buf_a_we),
    .waddr (buf_a_waddr),
    .wdata (buf_a_wdata),
    .raddr (rd_addr),
    .rdata (buf_a_rdata)
  );

  feature_bram buf_b_inst (
    .clk   (clk),
    .we    (buf_b_we),
    .waddr (wr_addr_d[4]),
    .wdata (result),
    .raddr (buf_b_raddr),
    .rdata (buf_b_rdata)
  );

  feature_bram skip_buf_inst (
    .clk   (clk),
    .we    (host_wr),
    .waddr (host_addr),
    .wdata (host_data),
    .raddr (skip_addr),
    .rdata (skip_rdata)
  );

  coef_rom coef_rom_inst (
    .clk       (clk),
    .pass      (pass),
    .coef_addr (coef_addr),
    .weights   (rom_weights),
    .bias      (rom_bias)
  );

  operand_select operand_select_inst (
    .clk        (clk),
    .arst_n     (arst_n),
    .pass       (pass_d[1]),
    .pad        (pad_d1),
    .buf_a_data (buf_a_rdata),
    .buf_b_data (buf_b_rdata),
    .skip_data  (skip_rdata),
    .weights_in (rom_weights),
    .bias_in    (rom_bias),
    .operand    (op_operand),
    .weights    (op_weights),
    .bias       (op_bias),
    .skip       (op_skip)
  );

  mac_array mac_array_inst (
    .clk          (clk),
    .arst_n       (arst_n),
    .valid        (step_d2),
    .first        (first_d2),
    .last         (last_d2),
    .residual     (residual),
    .operand      (op_operand),
    .weights      (op_weights),
    .bias         (op_bias),
    .skip         (op_skip),
    .result       (result),
    .result_valid (result_valid)
  );

endmodule

`default_nettype wire

//--- tb/tb_conv_layer.sv
`default_nettype none

module tb_conv_layer;

  import cnn_data_pkg::*;
  import cnn_pass_pkg::*;

  logic              clk = 1'b0;
  logic              arst_n;
  logic              host_wr;
  logic [addr_w-1:0] host_addr;
  logic [word_w-1:0] host_data;
  logic              step;
  pass_e             pass;
  logic [addr_w-1:0] rd_addr, skip_addr, wr_addr, out_addr;
  logic [coef_addr_w-1:0] coef_addr;
  logic              pad, first, last;
  logic [word_w-1:0] out_data, result;
  logic              result_valid;

  // reference model state
  logic [word_w-1:0] model_a [depth];
  logic [word_w-1:0] model_b [depth];
  logic [word_w-1:0] model_skip [depth];
  int                model_acc [lanes];

  // expected result per cycle count
  bit                exp_due [0:1023];
  logic [word_w-1:0] exp_word [0:1023];
  int                cyc = 0;
  int                errors = 0;
  int                checks = 0;

  conv_layer conv_layer_inst (
    .clk(clk), .arst_n(arst_n), .host_wr(host_wr), .host_addr(host_addr),
    .host_data(host_data), .step(step), .pass(pass), .rd_addr(rd_addr),
    .skip_addr(skip_addr), .coef_addr(coef_addr), .pad(pad), .first(first),
    .last(last), .wr_addr(wr_addr), .out_addr(out_addr), .out_data(out_data),
    .result(result), .result_valid(result_valid)
  );

  always #4 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  // result and result_valid against the expected schedule, every cycle
  always @(negedge clk) begin
    if (arst_n && cyc < 1024) begin
      checks++;
      assert (result_valid == exp_due[cyc]) else begin
        $display("ERR result_valid got %h exp %h at cycle %0d", result_valid, exp_due[cyc], cyc);
        errors++;
      end
      if (exp_due[cyc]) begin
        checks++;
        assert (result == exp_word[cyc]) else begin
          $display("ERR result got %h exp %h at cycle %0d", result, exp_word[cyc], cyc);
          errors++;
        end
      end
    end
  end

  function automatic int lane_of(logic [word_w-1:0] w, int i);
    logic signed [data_w-1:0] v;
    v = w[i*data_w +: data_w];
    return int'(v);
  endfunction

  // quarter steps from -1.0 to +1.0
  function automatic int tile_weight(int p, int c, int o, int i);
    return ((p * 7 + c * 3 + o * 5 + i) % 9 - 4) * 64;
  endfunction

  function automatic int clamp(int v);
    if (v > 32767) begin
      return 32767;
    end else if (v < -32768) begin
      return -32768;
    end
    return v;
  endfunction

  function automatic logic [word_w-1:0] rand_word(bit big);
    logic [word_w-1:0] w;
    for (int i = 0; i < lanes; i++) begin
      w[i*data_w +: data_w] = big ? data_w'($urandom) : data_w'(($urandom % 2048) - 1024);
    end
    return w;
  endfunction

  task automatic host_load(input int a, input logic [word_w-1:0] d);
    host_wr = 1'b1;
    host_addr = addr_w'(a);
    host_data = d;
    model_a[a] = d;
    model_skip[a] = d;
    @(negedge clk);
    host_wr = 1'b0;
  endtask

  // drive one step and run it through the model
  task automatic issue_step(input pass_e p, input int rd, input int sk, input int c,
                            input bit pd, input bit f, input bit l, input int wa);
    logic [word_w-1:0] src;
    logic [word_w-1:0] res;
    int s;
    int t;
    src = (int'(p) % 2 == 1) ? model_b[rd] : model_a[rd];
    if (pd) begin
      src = '0;
    end
    for (int o = 0; o < lanes; o++) begin
      s = 0;
      for (int i = 0; i < lanes; i++) begin
        s += (lane_of(src, i) * tile_weight(int'(p), c, o, i)) >>> frac_bits;
      end
      model_acc[o] = f ? s : model_acc[o] + s;
      t = model_acc[o] + (int'(p) - 2 + o) * 32;
      if (p == pass_4) begin
        t += lane_of(model_skip[sk], o);
      end
      res[o*data_w +: data_w] = data_w'(clamp(t));
    end
    step = 1'b1;
    pass = p;
    rd_addr = addr_w'(rd);
    skip_addr = addr_w'(sk);
    coef_addr = coef_addr_w'(c);
    pad = pd;
    first = f;
    last = l;
    wr_addr = addr_w'(wa);
    if (l) begin
      exp_due[cyc + 4] = 1'b1;
      exp_word[cyc + 4] = res;
      if (int'(p) % 2 == 1) begin
        model_a[wa] = res;
      end else begin
        model_b[wa] = res;
      end
    end
    @(negedge clk);
  endtask

  task automatic idle();
    step = 1'b0;
    pad = 1'b0;
    first = 1'b0;
    last = 1'b0;
  endtask

  // pulse train up, then down, so the last write has landed
  task automatic wait_result();
    int n;
    n = 0;
    while (!result_valid && n < 12) begin
      @(negedge clk);
      n++;
    end
    if (!result_valid) begin
      $display("result_valid never rose after the last step");
      errors++;
    end
    n = 0;
    while (result_valid && n < 12) begin
      @(negedge clk);
      n++;
    end
    if (result_valid) begin
      $display("result_valid stuck high");
      errors++;
    end
  endtask

  task automatic check_out(input int a);
    out_addr = addr_w'(a);
    @(negedge clk);
    checks++;
    assert (out_data == model_b[a]) else begin
      $display("ERR out_data[%0d] got %h exp %h", a, out_data, model_b[a]);
      errors++;
    end
  endtask

  initial begin
    void'($urandom(28));
    arst_n = 1'b0;
    host_wr = 1'b0;
    host_addr = '0;
    host_data = '0;
    pass = pass_0;
    rd_addr = '0;
    skip_addr = '0;
    coef_addr = '0;
    wr_addr = '0;
    out_addr = '0;
    idle();
    repeat (3) @(negedge clk);
    arst_n = 1'b1;
    for (int a = 0; a < 8; a++) host_load(a, rand_word(1'b0));
    // full range words for the clamp
    for (int a = 8; a < 12; a++) host_load(a, rand_word(1'b1));
    // every lane at the top of the range
    host_load(12, {lanes{data_max}});
    repeat (5) @(negedge clk);
    // even pass, three steps
    issue_step(pass_0, 0, 0, 0, 1'b0, 1'b1, 1'b0, 5);
    issue_step(pass_0, 1, 0, 1, 1'b0, 1'b0, 1'b0, 5);
    issue_step(pass_0, 2, 0, 2, 1'b0, 1'b0, 1'b1, 5);
    idle();
    wait_result();
    check_out(5);
    // padded middle step
    issue_step(pass_2, 3, 0, 0, 1'b0, 1'b1, 1'b0, 6);
    issue_step(pass_2, 4, 0, 1, 1'b1, 1'b0, 1'b0, 6);
    issue_step(pass_2, 5, 0, 2, 1'b0, 1'b0, 1'b1, 6);
    idle();
    wait_result();
    check_out(6);
    // odd pass back into buffer a, then chained even pass
    issue_step(pass_1, 5, 0, 3, 1'b0, 1'b1, 1'b0, 20);
    issue_step(pass_1, 6, 0, 4, 1'b0, 1'b0, 1'b1, 20);
    idle();
    wait_result();
    issue_step(pass_2, 20, 0, 5, 1'b0, 1'b1, 1'b1, 21);
    idle();
    wait_result();
    check_out(21);
    // residual pass with large inputs
    issue_step(pass_4, 8, 9, 0, 1'b0, 1'b1, 1'b0, 30);
    issue_step(pass_4, 10, 9, 1, 1'b0, 1'b0, 1'b0, 30);
    issue_step(pass_4, 11, 9, 2, 1'b0, 1'b0, 1'b1, 30);
    // lane 0 clamps low and lane 1 clamps high with tile 0
    issue_step(pass_4, 12, 1, 0, 1'b0, 1'b1, 1'b1, 31);
    idle();
    wait_result();
    check_out(30);
    check_out(31);
    // one-step words back to back
    for (int k = 0; k < 4; k++) begin
      issue_step(pass_0, k, 0, k + 3, 1'b0, 1'b1, 1'b1, 40 + k);
    end
    idle();
    wait_result();
    for (int k = 0; k < 4; k++) check_out(40 + k);
    repeat (2) @(negedge clk);
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
hw/cnn_data_pkg.sv
hw/cnn_pass_pkg.sv
hw/feature_bram.sv
hw/coef_rom.sv
hw/operand_select.sv
hw/mac_array.sv
hw/conv_layer.sv
tb/tb_conv_layer.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_conv_layer -f filelist.f

out=$(./obj_dir/Vtb_conv_layer)
echo "$out"

# grep fails the script when the pass line is missing
echo "$out" | grep -qx "Regression passed"
